// File: hdl/wb_config.svh
`ifndef WB_CONFIG_SVH
`define WB_CONFIG_SVH

// result slots carried by one retiring instruction
`define WB_SLOTS    4

// pending stores held ahead of memory
`define WBAQ_DEPTH  4

// architectural register counts
`define GPR_COUNT   8
`define SEG_COUNT   6

// width of slot destinations and store addresses
`define WB_ADDR_W   32

`endif

// File: hdl/arch_pkg.sv
`default_nettype none

package arch_pkg;

    // general register index, eax..edi
    typedef logic [2:0] gpr_idx_t;

    // segment register index
    typedef logic [2:0] seg_idx_t;

    typedef enum logic [2:0] {
        ES = 3'd0,
        CS = 3'd1,
        SS = 3'd2,
        DS = 3'd3,
        FS = 3'd4,
        GS = 3'd5
    } seg_e;

    // operand size of the retiring instruction
    typedef enum logic [1:0] {
        SZ_BYTE  = 2'd0,
        SZ_WORD  = 2'd1,
        SZ_DWORD = 2'd2
    } size_e;

    // bit 3 marks an external interrupt, 2:0 the cause
    typedef logic [3:0] ie_type_t;

endpackage

`default_nettype wire

// File: hdl/pipe_pkg.sv
`default_nettype none

`include "wb_config.svh"

package pipe_pkg;

    typedef enum logic [1:0] {
        OP_NORMAL  = 2'd0,
        OP_HALT    = 2'd1,
        OP_FAR_JMP = 2'd2
    } wb_op_e;

    typedef struct packed {
        logic [63:0]            data;
        logic [`WB_ADDR_W-1:0]  dest;   // reg/seg index in low bits, or mem address
        logic                   is_reg;
        logic                   is_seg;
        logic                   is_mem;
        logic                   wb;
    } wb_slot_t;

    typedef struct packed {
        logic                           valid;
        wb_op_e                         op;
        arch_pkg::size_e                size;
        wb_slot_t [`WB_SLOTS-1:0]       slot;
        logic [31:0]                    eip;        // next sequential
        logic                           br_valid;
        logic                           br_taken;
        logic                           br_correct;
        logic [31:0]                    br_fip;
        logic [31:0]                    br_fip_p1;
        logic                           ie;
        arch_pkg::ie_type_t             ie_type;
    } wb_inst_t;

    typedef struct packed {
        logic               en;
        arch_pkg::gpr_idx_t idx;
        arch_pkg::size_e    size;
        logic [31:0]        data;
    } gpr_wr_t;

    typedef struct packed {
        logic               en;
        arch_pkg::seg_idx_t idx;
        logic [15:0]        data;
    } seg_wr_t;

    typedef struct packed {
        logic                   valid;
        logic [`WB_ADDR_W-1:0]  addr;
        logic [63:0]            data;
        arch_pkg::size_e        size;
    } mem_req_t;

    typedef struct packed {
        logic [31:0] new_eip;
        logic [31:0] new_fip_e;
        logic [31:0] new_fip_o;
        logic        is_resteer;
    } wb_redirect_t;

    typedef struct packed {
        logic               valid_out;
        logic               ie_val;
        arch_pkg::ie_type_t ie_type;
    } wb_event_t;

endpackage

`default_nettype wire

// File: hdl/writeback_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "wb_config.svh"

module writeback_stage (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  pipe_pkg::wb_inst_t                  inst,
    input  wire                                 interrupt,
    input  wire                                 aq_full,
    output pipe_pkg::gpr_wr_t [`WB_SLOTS-1:0]   gpr_wr,
    output pipe_pkg::seg_wr_t [`WB_SLOTS:0]     seg_wr,
    output pipe_pkg::mem_req_t                  push,
    output logic                                stall,
    output pipe_pkg::wb_redirect_t              redirect,
    output pipe_pkg::wb_event_t                 wb_event,
    output logic                                halted
);

    localparam int FAR_SLOT = 1;   // far pointer rides in this slot

    logic                   valid_int;
    logic                   far_jmp;
    logic [`WB_SLOTS-1:0]   store_sel;
    logic                   any_store;

    assign far_jmp = inst.valid & (inst.op == pipe_pkg::OP_FAR_JMP);

    // slot wants a store, independent of gating
    always_comb begin
        for (int i = 0; i < `WB_SLOTS; i++) begin
            store_sel[i] = inst.slot[i].is_mem & inst.slot[i].wb;
        end
    end

    assign any_store = |store_sel;
    assign stall     = inst.valid & any_store & aq_full;
    assign valid_int = inst.valid & ~stall & ~halted;

    // per-slot register and segment writes
    always_comb begin
        for (int i = 0; i < `WB_SLOTS; i++) begin
            gpr_wr[i].en   = valid_int & inst.slot[i].is_reg & inst.slot[i].wb;
            gpr_wr[i].idx  = inst.slot[i].dest[2:0];
            gpr_wr[i].size = inst.size;
            gpr_wr[i].data = inst.slot[i].data[31:0];

            seg_wr[i].en   = valid_int & inst.slot[i].is_seg & inst.slot[i].wb;
            seg_wr[i].idx  = inst.slot[i].dest[2:0];
            seg_wr[i].data = inst.slot[i].data[15:0];
        end
        // extra port for CS load on far jump, last so it wins
        seg_wr[`WB_SLOTS].en   = valid_int & far_jmp;
        seg_wr[`WB_SLOTS].idx  = arch_pkg::seg_idx_t'(arch_pkg::CS);
        seg_wr[`WB_SLOTS].data = inst.slot[FAR_SLOT].data[47:32];
    end

    // lowest-numbered storing slot goes to the queue
    always_comb begin
        int pick;
        pick = 0;
        for (int i = `WB_SLOTS - 1; i >= 0; i--) begin
            if (store_sel[i]) begin
                pick = i;
            end
        end
        push.valid = valid_int & any_store;
        push.addr  = inst.slot[pick].dest;
        push.data  = inst.slot[pick].data;
        push.size  = inst.size;
    end

    // redirect
    always_comb begin
        if (far_jmp) begin
            redirect.new_eip = inst.slot[FAR_SLOT].data[31:0];
        end else if (inst.br_taken) begin
            redirect.new_eip = inst.br_fip;
        end else begin
            redirect.new_eip = inst.eip;
        end

        if (inst.br_fip[4]) begin   // target sits in odd block
            redirect.new_fip_e = {inst.br_fip_p1[31:4], 4'h0};
            redirect.new_fip_o = {inst.br_fip[31:4], 4'h0};
        end else begin
            redirect.new_fip_e = {inst.br_fip[31:4], 4'h0};
            redirect.new_fip_o = {inst.br_fip_p1[31:4], 4'h0};
        end

        redirect.is_resteer = valid_int & inst.br_valid & ~inst.br_correct;
    end

    // exception merge
    assign wb_event.valid_out    = valid_int;
    assign wb_event.ie_val       = (valid_int & inst.ie) | interrupt;
    assign wb_event.ie_type[2:0] = inst.ie_type[2:0];
    assign wb_event.ie_type[3]   = interrupt;   // external source flag

    // sticky halt, cleared only by reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            halted <= 1'b0;
        end else if (valid_int && inst.op == pipe_pkg::OP_HALT) begin
            halted <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hdl/gpr_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "wb_config.svh"

module gpr_file (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  pipe_pkg::gpr_wr_t [`WB_SLOTS-1:0]   wr,
    input  arch_pkg::gpr_idx_t                  rd_idx,
    output logic [31:0]                         rd_data
);

    logic [31:0] regs      [`GPR_COUNT];
    logic [31:0] regs_next [`GPR_COUNT];

    // byte/word writes keep the upper bits
    function automatic logic [31:0] merge(
        input logic [31:0]     old_val,
        input logic [31:0]     new_val,
        input arch_pkg::size_e size
    );
        logic [31:0] result;
        result = old_val;
        case (size)
            arch_pkg::SZ_BYTE: result[7:0]  = new_val[7:0];
            arch_pkg::SZ_WORD: result[15:0] = new_val[15:0];
            default:           result       = new_val;
        endcase
        return result;
    endfunction

    // ports applied in order, so later slots win
    always_comb begin
        regs_next = regs;
        for (int p = 0; p < `WB_SLOTS; p++) begin
            if (wr[p].en) begin
                regs_next[wr[p].idx] = merge(regs_next[wr[p].idx], wr[p].data, wr[p].size);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs <= '{default: '0};
        end else begin
            regs <= regs_next;
        end
    end

    assign rd_data = regs[rd_idx];

endmodule

`default_nettype wire

// File: hdl/seg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "wb_config.svh"

module seg_file (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  pipe_pkg::seg_wr_t [`WB_SLOTS:0]     wr,
    input  arch_pkg::seg_idx_t                  rd_idx,
    output logic [15:0]                         rd_data
);

    logic [15:0] regs [`SEG_COUNT];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs <= '{default: '0};
        end else begin
            // highest port last, far-jump CS wins
            for (int p = 0; p <= `WB_SLOTS; p++) begin
                if (wr[p].en && int'(wr[p].idx) < `SEG_COUNT) begin
                    regs[wr[p].idx] <= wr[p].data;
                end
            end
        end
    end

    always_comb begin
        if (int'(rd_idx) < `SEG_COUNT) begin
            rd_data = regs[rd_idx];
        end else begin
            rd_data = '0;   // indexes 6,7 unmapped
        end
    end

endmodule

`default_nettype wire

// File: hdl/wb_addr_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "wb_config.svh"

module wb_addr_queue (
    input  wire                 clk,
    input  wire                 rst_n,
    input  pipe_pkg::mem_req_t  push,
    input  wire                 mem_ack,
    output logic                full,
    output pipe_pkg::mem_req_t  head
);

    localparam int DEPTH = `WBAQ_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    pipe_pkg::mem_req_t mem [DEPTH];

    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               do_push;
    logic               do_pop;

    assign full    = (count == CNT_W'(DEPTH));
    assign do_push = push.valid & ~full;
    assign do_pop  = mem_ack & (count != '0);   // ack with empty queue ignored

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // oldest store, valid only when queue holds one
    always_comb begin
        head       = mem[rd_ptr];
        head.valid = (count != '0);
    end

endmodule

`default_nettype wire

// File: hdl/wb_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

`include "wb_config.svh"

module wb_subsystem (
    input  wire                     clk,
    input  wire                     rst_n,
    input  pipe_pkg::wb_inst_t      inst,
    input  wire                     interrupt,
    input  wire                     mem_ack,
    output logic                    stall,
    output pipe_pkg::wb_redirect_t  redirect,
    output pipe_pkg::wb_event_t     wb_event,
    output pipe_pkg::mem_req_t      mem_req,
    input  arch_pkg::gpr_idx_t      gpr_rd_idx,
    output logic [31:0]             gpr_rd_data,
    input  arch_pkg::seg_idx_t      seg_rd_idx,
    output logic [15:0]             seg_rd_data,
    output logic                    halted
);

    pipe_pkg::gpr_wr_t [`WB_SLOTS-1:0]  gpr_wr;
    pipe_pkg::seg_wr_t [`WB_SLOTS:0]    seg_wr;   // slots plus far-jump CS
    pipe_pkg::mem_req_t                 push;
    logic                               aq_full;

    writeback_stage u_stage (
        .clk      (clk),
        .rst_n    (rst_n),
        .inst     (inst),
        .interrupt(interrupt),
        .aq_full  (aq_full),
        .gpr_wr   (gpr_wr),
        .seg_wr   (seg_wr),
        .push     (push),
        .stall    (stall),
        .redirect (redirect),
        .wb_event (wb_event),
        .halted   (halted)
    );

    gpr_file u_gpr (
        .clk    (clk),
        .rst_n  (rst_n),
        .wr     (gpr_wr),
        .rd_idx (gpr_rd_idx),
        .rd_data(gpr_rd_data)
    );

    seg_file u_seg (
        .clk    (clk),
        .rst_n  (rst_n),
        .wr     (seg_wr),
        .rd_idx (seg_rd_idx),
        .rd_data(seg_rd_data)
    );

    wb_addr_queue u_waq (
        .clk    (clk),
        .rst_n  (rst_n),
        .push   (push),
        .mem_ack(mem_ack),
        .full   (aq_full),
        .head   (mem_req)
    );

endmodule

`default_nettype wire

// File: tb/wb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module wb_clk_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;   // 4 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: tb/wb_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "wb_config.svh"

module wb_tb;

    typedef struct packed {
        pipe_pkg::wb_inst_t     inst;
        logic                   intr;
        logic                   ack;
        arch_pkg::gpr_idx_t     gidx;
        arch_pkg::seg_idx_t     sidx;
        logic                   stall;
        pipe_pkg::wb_redirect_t redir;
        pipe_pkg::wb_event_t    ev;
        pipe_pkg::mem_req_t     head;
        logic                   halted;
        logic [31:0]            gval;
        logic [15:0]            sval;
    } step_t;

    logic                   clk;
    logic                   rst_n;
    pipe_pkg::wb_inst_t     inst;
    logic                   interrupt;
    logic                   mem_ack;
    logic                   stall;
    pipe_pkg::wb_redirect_t redirect;
    pipe_pkg::wb_event_t    wb_event;
    pipe_pkg::mem_req_t     mem_req;
    arch_pkg::gpr_idx_t     gpr_rd_idx;
    logic [31:0]            gpr_rd_data;
    arch_pkg::seg_idx_t     seg_rd_idx;
    logic [15:0]            seg_rd_data;
    logic                   halted;

    step_t                  steps [$];
    logic [31:0]            gpr_m [`GPR_COUNT];   // shadow registers
    logic [15:0]            seg_m [`SEG_COUNT];
    pipe_pkg::mem_req_t     store_m [$];          // shadow store queue
    logic                   halted_m = 1'b0;
    arch_pkg::gpr_idx_t     next_g = '0;
    arch_pkg::seg_idx_t     next_s = '0;
    integer                 seed = 52;
    int                     errors = 0;
    int                     checks = 0;
    int                     cycles = 0;
    int                     limit = 0;

    wb_clk_gen u_clk (.clk(clk), .rst_n(rst_n));

    wb_subsystem DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst       (inst),
        .interrupt  (interrupt),
        .mem_ack    (mem_ack),
        .stall      (stall),
        .redirect   (redirect),
        .wb_event   (wb_event),
        .mem_req    (mem_req),
        .gpr_rd_idx (gpr_rd_idx),
        .gpr_rd_data(gpr_rd_data),
        .seg_rd_idx (seg_rd_idx),
        .seg_rd_data(seg_rd_data),
        .halted     (halted)
    );

    task automatic check(input logic [127:0] actual, input logic [127:0] expected,
                         input string msg);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, msg, actual, expected);
        end
    endtask

    function automatic pipe_pkg::wb_slot_t make_slot(input int kind, input logic [31:0] dest,
                                                     input logic wb);
        pipe_pkg::wb_slot_t s;
        s        = '0;
        s.data   = {$random(seed), $random(seed)};
        s.dest   = dest;
        s.is_reg = (kind == 1);
        s.is_seg = (kind == 2);
        s.is_mem = (kind == 3);
        s.wb     = wb;
        return s;
    endfunction

    function automatic pipe_pkg::wb_inst_t new_inst(input arch_pkg::size_e size);
        pipe_pkg::wb_inst_t i;
        i           = '0;
        i.valid     = 1'b1;
        i.op        = pipe_pkg::OP_NORMAL;
        i.size      = size;
        i.eip       = $random(seed);
        i.br_fip    = $random(seed);
        i.br_fip_p1 = i.br_fip + 32'd16;
        return i;
    endfunction

    // narrow writes keep the untouched upper bits
    function automatic logic [31:0] merge(input logic [31:0] old_val, input logic [31:0] val,
                                          input arch_pkg::size_e size);
        if (size == arch_pkg::SZ_BYTE) return {old_val[31:8], val[7:0]};
        if (size == arch_pkg::SZ_WORD) return {old_val[31:16], val[15:0]};
        return val;
    endfunction

    // append one step with its expected outputs, then advance the shadow state
    task automatic add(input pipe_pkg::wb_inst_t i, input logic intr, input logic ack);
        step_t              e;
        pipe_pkg::mem_req_t m;
        logic               any_store;
        logic               v;
        logic               fj;
        logic               found;
        e        = '0;
        e.inst   = i;
        e.intr   = intr;
        e.ack    = ack;
        e.gidx   = next_g;
        e.sidx   = next_s;
        e.gval   = gpr_m[next_g];
        e.sval   = seg_m[next_s];
        e.halted = halted_m;
        if (store_m.size() > 0) e.head = store_m[0];
        any_store = 1'b0;
        for (int k = 0; k < `WB_SLOTS; k++) any_store |= i.slot[k].is_mem & i.slot[k].wb;
        e.stall = i.valid & any_store & (store_m.size() == `WBAQ_DEPTH);
        v  = i.valid & ~e.stall & ~halted_m;
        fj = i.valid && i.op == pipe_pkg::OP_FAR_JMP;
        e.redir.new_eip    = fj ? i.slot[1].data[31:0] : (i.br_taken ? i.br_fip : i.eip);
        e.redir.new_fip_e  = i.br_fip[4] ? {i.br_fip_p1[31:4], 4'h0} : {i.br_fip[31:4], 4'h0};
        e.redir.new_fip_o  = i.br_fip[4] ? {i.br_fip[31:4], 4'h0} : {i.br_fip_p1[31:4], 4'h0};
        e.redir.is_resteer = v & i.br_valid & ~i.br_correct;
        e.ev.valid_out     = v;
        e.ev.ie_val        = (v & i.ie) | intr;
        e.ev.ie_type       = {intr, i.ie_type[2:0]};
        steps.push_back(e);
        if (ack && store_m.size() > 0) void'(store_m.pop_front());
        if (v) begin
            found = 1'b0;
            for (int k = 0; k < `WB_SLOTS; k++) begin
                if (i.slot[k].wb && i.slot[k].is_reg) begin
                    gpr_m[i.slot[k].dest[2:0]] = merge(gpr_m[i.slot[k].dest[2:0]],
                                                       i.slot[k].data[31:0], i.size);
                    next_g = i.slot[k].dest[2:0];
                end
                if (i.slot[k].wb && i.slot[k].is_seg && i.slot[k].dest < `SEG_COUNT) begin
                    seg_m[i.slot[k].dest[2:0]] = i.slot[k].data[15:0];
                    next_s = i.slot[k].dest[2:0];
                end
                if (i.slot[k].wb && i.slot[k].is_mem && !found) begin
                    m = {1'b1, i.slot[k].dest, i.slot[k].data, i.size};
                    store_m.push_back(m);
                    found = 1'b1;
                end
            end
            if (fj) begin
                seg_m[arch_pkg::CS] = i.slot[1].data[47:32];   // far pointer selector
                next_s = arch_pkg::CS;
            end
            if (i.op == pipe_pkg::OP_HALT) halted_m = 1'b1;
        end
    endtask

    // idle steps reading back every register
    task automatic sweep();
        for (int k = 0; k < `GPR_COUNT; k++) begin
            next_g = arch_pkg::gpr_idx_t'(k);
            next_s = arch_pkg::seg_idx_t'(k % `SEG_COUNT);
            add('0, 1'b0, 1'b0);
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: run went past %0d cycles without finishing", limit);
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        pipe_pkg::wb_inst_t i;
        step_t              e;
        inst       = '0;
        interrupt  = 1'b0;
        mem_ack    = 1'b0;
        gpr_rd_idx = '0;
        seg_rd_idx = '0;
        gpr_m      = '{default: '0};
        seg_m      = '{default: '0};

        for (int sz = 0; sz < 3; sz++) begin   // dword, word, byte
            i = new_inst(arch_pkg::size_e'(2 - sz));
            for (int k = 0; k < 4; k++) i.slot[k] = make_slot(1, (3 * sz + k) % 8, 1'b1);
            add(i, 1'b0, 1'b0);
        end
        i = new_inst(arch_pkg::SZ_DWORD);
        i.slot[0] = make_slot(2, arch_pkg::DS, 1'b1);
        i.slot[1] = make_slot(2, arch_pkg::SS, 1'b1);
        i.slot[2] = make_slot(2, arch_pkg::DS, 1'b1);
        i.slot[3] = make_slot(2, arch_pkg::GS, 1'b0);
        add(i, 1'b0, 1'b0);
        i = new_inst(arch_pkg::SZ_WORD);
        i.slot[0] = make_slot(1, 2, 1'b1);
        i.slot[1] = make_slot(1, 5, 1'b0);
        i.slot[2] = make_slot(1, 2, 1'b1);
        add(i, 1'b0, 1'b0);
        i = new_inst(arch_pkg::SZ_BYTE);
        i.slot[1] = make_slot(1, 3, 1'b1);
        i.slot[3] = make_slot(1, 3, 1'b1);
        add(i, 1'b0, 1'b0);
        i = new_inst(arch_pkg::SZ_DWORD);
        i.slot[0] = make_slot(1, 6, 1'b1);
        i.valid   = 1'b0;
        add(i, 1'b0, 1'b0);
        sweep();

        for (int n = 0; n < 5; n++) begin   // fifth one finds the queue full
            i = new_inst(arch_pkg::size_e'(n % 3));
            i.slot[0] = make_slot(1, n, 1'b1);
            i.slot[1] = make_slot(3, $random(seed), 1'b0);
            i.slot[2] = make_slot(3, $random(seed), 1'b1);
            i.slot[3] = make_slot(3, $random(seed), 1'b1);
            if (n == 4) next_g = arch_pkg::gpr_idx_t'(n);   // held write must not land
            add(i, 1'b0, 1'b0);
        end
        add(i, 1'b0, 1'b1);
        add(i, 1'b0, 1'b0);
        repeat (5) add('0, 1'b0, 1'b1);   // last ack hits an empty queue

        for (int n = 0; n < 6; n++) begin
            i = new_inst(arch_pkg::SZ_DWORD);
            i.br_fip[4]  = n[0];
            i.br_fip_p1  = i.br_fip + 32'd16;
            i.br_valid   = 1'b1;
            i.br_taken   = (n >= 2);
            i.br_correct = (n < 4);
            add(i, 1'b0, 1'b0);
        end

        i = new_inst(arch_pkg::SZ_DWORD);
        i.op       = pipe_pkg::OP_FAR_JMP;
        i.br_taken = 1'b1;
        i.slot[1]  = make_slot(0, 0, 1'b0);
        i.slot[3]  = make_slot(2, arch_pkg::CS, 1'b1);
        add(i, 1'b0, 1'b0);
        add('0, 1'b0, 1'b0);

        i = new_inst(arch_pkg::SZ_DWORD);
        i.ie      = 1'b1;
        i.ie_type = 4'h5;
        add(i, 1'b0, 1'b0);
        i.ie_type = 4'hb;
        add(i, 1'b1, 1'b0);
        i.ie = 1'b0;
        add(i, 1'b1, 1'b0);
        i.valid = 1'b0;
        i.ie    = 1'b1;
        add(i, 1'b0, 1'b0);
        i = new_inst(arch_pkg::SZ_DWORD);
        i.op      = pipe_pkg::OP_HALT;
        i.slot[0] = make_slot(1, 7, 1'b1);
        add(i, 1'b0, 1'b0);
        i = new_inst(arch_pkg::SZ_DWORD);
        i.ie      = 1'b1;
        i.slot[0] = make_slot(1, 7, 1'b1);
        i.slot[1] = make_slot(2, arch_pkg::ES, 1'b1);
        add(i, 1'b1, 1'b0);
        sweep();

        limit = 4 * steps.size() + 50;
        @(posedge rst_n);
        foreach (steps[n]) begin
            @(negedge clk);
            e          = steps[n];
            inst       = e.inst;
            interrupt  = e.intr;
            mem_ack    = e.ack;
            gpr_rd_idx = e.gidx;
            seg_rd_idx = e.sidx;
            #1;
            check(stall, e.stall, $sformatf("step %0d stall", n));
            check(redirect, e.redir, $sformatf("step %0d redirect", n));
            check(wb_event, e.ev, $sformatf("step %0d event", n));
            check(mem_req.valid, e.head.valid, $sformatf("step %0d mem_req valid", n));
            if (e.head.valid) begin
                check({mem_req.addr, mem_req.data, mem_req.size},
                      {e.head.addr, e.head.data, e.head.size},
                      $sformatf("step %0d mem_req addr/data/size", n));
            end
            check(halted, e.halted, $sformatf("step %0d halted", n));
            check(gpr_rd_data, e.gval, $sformatf("step %0d gpr %0d", n, e.gidx));
            check(seg_rd_data, e.sval, $sformatf("step %0d seg %0d", n, e.sidx));
        end
        @(negedge clk);
        inst      = '0;
        interrupt = 1'b0;
        mem_ack   = 1'b0;
        $display("%0d errors in %0d checks over %0d steps", errors, checks, steps.size());
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+hdl
hdl/arch_pkg.sv
hdl/pipe_pkg.sv
hdl/writeback_stage.sv
hdl/gpr_file.sv
hdl/seg_file.sv
hdl/wb_addr_queue.sv
hdl/wb_subsystem.sv
tb/wb_clk_gen.sv
tb/wb_tb.sv
